/* mem_config.svh */
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// Width of the data path and of the byte address.
`define MEM_DATA_W 32

// Number of 32-bit words in the RAM.
// The word index wraps modulo this size.
`define MEM_WORDS 256

// Depth of the response FIFO.
// The requester starts with this many credits.
`define MEM_CREDITS 4

// Width of the requester tag echoed in every response.
`define MEM_TAG_W 4

`endif

/* mem_pkg.sv */
`include "mem_config.svh"

package mem_pkg;

    // Store and load opcodes seen by the memory-access stage.
    typedef enum logic [2:0] {
        op_sw,
        op_sh,
        op_sb,
        op_lw,
        op_lh,
        op_lhu,
        op_lb,
        op_lbu
    } mem_op_e;

    // One request as presented by the pipeline.
    typedef struct packed {
        mem_op_e                op;
        logic [`MEM_DATA_W-1:0] addr;
        logic [`MEM_DATA_W-1:0] wdata;
        logic [`MEM_TAG_W-1:0]  tag;
    } mem_req_t;

    // Store data moved onto its byte lanes, with one enable per lane.
    typedef struct packed {
        logic [`MEM_DATA_W-1:0]   data;
        logic [`MEM_DATA_W/8-1:0] be;
    } store_lane_t;

    // One response per request, returned in request order.
    typedef struct packed {
        logic [`MEM_TAG_W-1:0]  tag;
        logic                   is_load;
        logic                   err;
        logic [`MEM_DATA_W-1:0] rdata;
    } mem_resp_t;

endpackage

/* store_align.sv */
`timescale 1ns/10ps

module store_align (
    input  mem_pkg::mem_req_t    req,
    output mem_pkg::store_lane_t lane
);

    // The byte offset within the word picks the target lane.
    always_comb begin
        lane = '0;
        case (req.op)
            ////////////////////////////////////////
            // Byte store.
            ////////////////////////////////////////
            mem_pkg::op_sb: begin
                lane.data = {24'd0, req.wdata[7:0]} << {req.addr[1:0], 3'b000};
                lane.be   = 4'b0001 << req.addr[1:0];
            end

            ////////////////////////////////////////
            // Half store.
            ////////////////////////////////////////
            mem_pkg::op_sh: begin
                if (req.addr[1]) begin
                    lane.data = {req.wdata[15:0], 16'd0};
                    lane.be   = 4'b1100;
                end else begin
                    lane.data = {16'd0, req.wdata[15:0]};
                    lane.be   = 4'b0011;
                end
            end

            ////////////////////////////////////////
            // Word store.
            ////////////////////////////////////////
            mem_pkg::op_sw: begin
                lane.data = req.wdata;
                lane.be   = 4'b1111;
            end

            // Loads drive nothing onto the lanes.
            default: begin
                lane = '0;
            end
        endcase
    end

endmodule

/* addr_check.sv */
`timescale 1ns/10ps

module addr_check (
    input  mem_pkg::mem_req_t req,
    output logic              misaligned
);

    // Half accesses need an even address, word accesses a 4-byte boundary.
    // Byte accesses can sit anywhere.
    always_comb begin
        misaligned = 1'b0;
        case (req.op)
            mem_pkg::op_sh,
            mem_pkg::op_lh,
            mem_pkg::op_lhu: begin
                misaligned = req.addr[0];
            end

            mem_pkg::op_sw,
            mem_pkg::op_lw: begin
                misaligned = (req.addr[1:0] != 2'b00);
            end

            default: begin
                misaligned = 1'b0;
            end
        endcase
    end

endmodule

/* resp_fifo.sv */
`timescale 1ns/10ps
`include "mem_config.svh"

module resp_fifo (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               push,
    input  mem_pkg::mem_resp_t push_resp,
    input  logic               resp_ready,
    output logic               resp_valid,
    output mem_pkg::mem_resp_t resp,
    output logic               credit_return
);

    localparam int ptr_w = $clog2(`MEM_CREDITS);

    mem_pkg::mem_resp_t q [`MEM_CREDITS];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [ptr_w:0]     count;
    logic               pop;

    assign resp_valid    = (count != '0);
    assign resp          = q[rd_ptr];
    assign pop           = resp_valid && resp_ready;
    // Every popped response hands one credit back to the requester.
    assign credit_return = pop;

    always_ff @(posedge clk) begin
        if (push) begin
            q[wr_ptr] <= push_resp;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(`MEM_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(`MEM_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The credit scheme upstream must keep the queue from overflowing.
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        push |-> (count != (ptr_w + 1)'(`MEM_CREDITS))
    );

endmodule

/* mem_access.sv */
`timescale 1ns/10ps
`include "mem_config.svh"

module mem_access (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid,
    input  mem_pkg::mem_req_t    req,
    input  mem_pkg::store_lane_t lane,
    input  logic                 misaligned,
    output logic                 push,
    output mem_pkg::mem_resp_t   push_resp
);

    localparam int idx_w = $clog2(`MEM_WORDS);

    logic [`MEM_DATA_W-1:0] ram [`MEM_WORDS];
    logic [idx_w-1:0]       idx;
    logic                   is_store;
    logic                   wr_en;

    // Stage one holds what the load path needs after the accepting edge.
    logic                   s1_valid;
    mem_pkg::mem_op_e       s1_op;
    logic [1:0]             s1_off;
    logic                   s1_err;
    logic [`MEM_TAG_W-1:0]  s1_tag;
    logic [`MEM_DATA_W-1:0] s1_word;

    logic [7:0]             ld_byte;
    logic [15:0]            ld_half;
    logic                   s1_is_load;
    logic [`MEM_DATA_W-1:0] ld_data;

    assign idx      = req.addr[idx_w+1:2];
    assign is_store = req.op inside {mem_pkg::op_sw, mem_pkg::op_sh, mem_pkg::op_sb};
    // Only aligned stores touch the RAM. Enables are zero for loads.
    assign wr_en    = req_valid && !misaligned && (lane.be != '0);

    ////////////////////////////////////////
    // Byte-enabled RAM.
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `MEM_WORDS; i++) begin
                ram[i] <= '0;
            end
        end else if (wr_en) begin
            for (int b = 0; b < `MEM_DATA_W / 8; b++) begin
                if (lane.be[b]) begin
                    ram[idx][8*b +: 8] <= lane.data[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            s1_op   <= req.op;
            s1_off  <= req.addr[1:0];
            s1_err  <= misaligned;
            s1_tag  <= req.tag;
            s1_word <= ram[idx];
        end
    end

    ////////////////////////////////////////
    // Load extraction and extension.
    ////////////////////////////////////////
    assign ld_byte    = s1_word[{s1_off, 3'b000} +: 8];
    assign ld_half    = s1_off[1] ? s1_word[31:16] : s1_word[15:0];
    assign s1_is_load = !(s1_op inside {mem_pkg::op_sw, mem_pkg::op_sh, mem_pkg::op_sb});

    always_comb begin
        case (s1_op)
            mem_pkg::op_lw:  ld_data = s1_word;
            mem_pkg::op_lh:  ld_data = {{(`MEM_DATA_W-16){ld_half[15]}}, ld_half};
            mem_pkg::op_lhu: ld_data = {{(`MEM_DATA_W-16){1'b0}}, ld_half};
            mem_pkg::op_lb:  ld_data = {{(`MEM_DATA_W-8){ld_byte[7]}}, ld_byte};
            mem_pkg::op_lbu: ld_data = {{(`MEM_DATA_W-8){1'b0}}, ld_byte};
            default:         ld_data = '0;
        endcase
    end

    // The formed response is registered, so the push comes one cycle after stage one.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            push <= 1'b0;
        end else begin
            push <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            push_resp.tag     <= s1_tag;
            push_resp.is_load <= s1_is_load;
            push_resp.err     <= s1_err;
            push_resp.rdata   <= s1_err ? '0 : ld_data;
        end
    end

    // The aligner must never raise lane enables for a load.
    a_be_store_only: assert property (
        @(posedge clk) disable iff (!rst_n)
        (req_valid && (lane.be != '0)) |-> is_store
    );

endmodule

/* mem_stage.sv */
`timescale 1ns/10ps

module mem_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req_valid,
    input  mem_pkg::mem_req_t  req,
    input  logic               resp_ready,
    output logic               credit_return,
    output logic               resp_valid,
    output mem_pkg::mem_resp_t resp
);

    mem_pkg::store_lane_t lane;
    logic                 misaligned;
    logic                 push;
    mem_pkg::mem_resp_t   push_resp;

    // The aligner and the alignment check both look at the same request.
    store_align store_align_i (
        .req  (req),
        .lane (lane)
    );

    addr_check addr_check_i (
        .req        (req),
        .misaligned (misaligned)
    );

    mem_access mem_access_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .lane       (lane),
        .misaligned (misaligned),
        .push       (push),
        .push_resp  (push_resp)
    );

    resp_fifo resp_fifo_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .push          (push),
        .push_resp     (push_resp),
        .resp_ready    (resp_ready),
        .resp_valid    (resp_valid),
        .resp          (resp),
        .credit_return (credit_return)
    );

endmodule

/* tb_mem_stage.sv */
`timescale 1ns/10ps
`include "mem_config.svh"

module tb_mem_stage;

    localparam int num_req        = 600;
    localparam int timeout_cycles = 4 * num_req + 200;

    logic               clk;
    logic               rst_n;
    logic               req_valid;
    mem_pkg::mem_req_t  req;
    logic               resp_ready;
    logic               credit_return;
    logic               resp_valid;
    mem_pkg::mem_resp_t resp;

    // Byte-addressed model of the first 16 RAM words, little-endian.
    logic [7:0]         model_mem [64];
    mem_pkg::mem_resp_t exp_q [$];
    int                 credits;
    int                 sent;
    int                 cycle_cnt;

    mem_stage mem_stage_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req           (req),
        .resp_ready    (resp_ready),
        .credit_return (credit_return),
        .resp_valid    (resp_valid),
        .resp          (resp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("Timeout after %0d cycles with %0d responses still due", cycle_cnt,
                     exp_q.size());
            $display("sim failed");
            $fatal(1, "run stopped on timeout");
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            $display("sim failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    task automatic model_request(input mem_pkg::mem_req_t r, output mem_pkg::mem_resp_t e);
        int   a;
        logic bad;
        a   = int'(r.addr[5:0]);
        bad = 1'b0;
        if (r.op inside {mem_pkg::op_sh, mem_pkg::op_lh, mem_pkg::op_lhu}) begin
            bad = r.addr[0];
        end
        if (r.op inside {mem_pkg::op_sw, mem_pkg::op_lw}) begin
            bad = (r.addr[1:0] != 2'b00);
        end
        e         = '0;
        e.tag     = r.tag;
        e.is_load = !(r.op inside {mem_pkg::op_sw, mem_pkg::op_sh, mem_pkg::op_sb});
        e.err     = bad;
        if (!bad) begin
            case (r.op)
                mem_pkg::op_sb: model_mem[a] = r.wdata[7:0];
                mem_pkg::op_sh: begin
                    model_mem[a]     = r.wdata[7:0];
                    model_mem[a + 1] = r.wdata[15:8];
                end
                mem_pkg::op_sw: begin
                    for (int i = 0; i < 4; i++) begin
                        model_mem[a + i] = r.wdata[8*i +: 8];
                    end
                end
                mem_pkg::op_lw:  e.rdata = {model_mem[a + 3], model_mem[a + 2],
                                            model_mem[a + 1], model_mem[a]};
                mem_pkg::op_lh:  e.rdata = {{16{model_mem[a + 1][7]}}, model_mem[a + 1],
                                            model_mem[a]};
                mem_pkg::op_lhu: e.rdata = {16'd0, model_mem[a + 1], model_mem[a]};
                mem_pkg::op_lb:  e.rdata = {{24{model_mem[a][7]}}, model_mem[a]};
                default:         e.rdata = {24'd0, model_mem[a]};
            endcase
        end
    endtask

    // Looks at the values present before the edge and scores a handshake.
    task automatic collect_response();
        mem_pkg::mem_resp_t e;
        check_value("credit_return", 32'(resp_valid && resp_ready), 32'(credit_return));
        if (resp_valid && resp_ready) begin
            if (exp_q.size() == 0) begin
                $display("A response arrived while no request was outstanding");
                $display("sim failed");
                $fatal(1, "unexpected response");
            end
            e = exp_q.pop_front();
            check_value("tag", 32'(e.tag), 32'(resp.tag));
            check_value("is_load", 32'(e.is_load), 32'(resp.is_load));
            check_value("err", 32'(e.err), 32'(resp.err));
            check_value("rdata", e.rdata, resp.rdata);
        end
        if (credit_return) begin
            credits++;
        end
    endtask

    task automatic issue_request();
        mem_pkg::mem_req_t  r;
        mem_pkg::mem_resp_t e;
        if (sent < num_req && credits > 0 && $urandom_range(0, 9) < 8) begin
            r.op   = mem_pkg::mem_op_e'(3'($urandom_range(0, 7)));
            r.addr = $urandom_range(0, 63);
            // Most accesses get natural alignment so that they reach the RAM.
            if ($urandom_range(0, 3) != 0) begin
                if (r.op inside {mem_pkg::op_sw, mem_pkg::op_lw}) begin
                    r.addr[1:0] = 2'b00;
                end else if (r.op inside {mem_pkg::op_sh, mem_pkg::op_lh, mem_pkg::op_lhu}) begin
                    r.addr[0] = 1'b0;
                end
            end
            r.wdata = $urandom();
            r.tag   = 4'(sent);
            model_request(r, e);
            exp_q.push_back(e);
            credits--;
            sent++;
            req       <= r;
            req_valid <= 1'b1;
        end else begin
            req_valid <= 1'b0;
        end
        resp_ready <= ($urandom_range(0, 9) >= 3);
    endtask

    initial begin
        void'($urandom(32'h4c99f10e));
        rst_n      <= 1'b0;
        req_valid  <= 1'b0;
        req        <= '0;
        resp_ready <= 1'b0;
        credits    = `MEM_CREDITS;
        sent       = 0;
        for (int i = 0; i < 64; i++) begin
            model_mem[i] = 8'h00;
        end
        repeat (16) @(posedge clk);
        rst_n      <= 1'b1;
        resp_ready <= 1'b1;

        // The stage stays quiet until the first request.
        repeat (8) begin
            @(posedge clk);
            check_value("idle resp_valid", 32'd0, 32'(resp_valid));
            check_value("idle credit_return", 32'd0, 32'(credit_return));
        end

        while (sent < num_req || exp_q.size() != 0) begin
            @(posedge clk);
            collect_response();
            issue_request();
        end

        // Nothing more may come out once every response has been taken.
        resp_ready <= 1'b1;
        repeat (8) begin
            @(posedge clk);
            collect_response();
        end

        $display("sim passed");
        $finish;
    end

endmodule

/* list.f */
+incdir+.
mem_pkg.sv
store_align.sv
addr_check.sv
resp_fifo.sv
mem_access.sv
mem_stage.sv
tb_mem_stage.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_mem_stage -o sim_mem_stage
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_mem_stage)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
